/* verilog.f */
+incdir+common
+incdir+test
common/ccm_pkg.sv
ecc/ecc_encode.sv
ecc/ecc_decode.sv
verilog/ccm_range_check.sv
verilog/ccm_resp_stage.sv
verilog/ccm_port_top.sv
test/tb_ccm_port.sv

/* test/tb_ccm_model.svh */
// ==========================================================================
// CCM port reference model
// ==========================================================================
`ifndef TB_CCM_MODEL_SVH
`define TB_CCM_MODEL_SVH

// codeword positions 1..38 sit in bits 0..37, overall parity in bit 38
// check bit k is at position 2**k, data fills the other positions in order
function automatic bit is_pow2(int p);
   return (p & (p - 1)) == 0;
endfunction

function automatic logic [`CCM_CW_W-1:0] to_codeword(ecc_word_t w);
   logic [`CCM_CW_W-1:0] cw;
   int                   d;
   int                   k;
   d = 0;
   k = 0;
   for (int p = 1; p < `CCM_CW_W; p++) begin
      if (is_pow2(p)) begin
         cw[p-1] = w.ecc[k];
         k++;
      end else begin
         cw[p-1] = w.data[d];
         d++;
      end
   end
   cw[`CCM_CW_W-1] = w.ecc[`CCM_ECC_W-1];
   return cw;
endfunction

function automatic ecc_word_t from_codeword(logic [`CCM_CW_W-1:0] cw);
   ecc_word_t w;
   int        d;
   int        k;
   d = 0;
   k = 0;
   for (int p = 1; p < `CCM_CW_W; p++) begin
      if (is_pow2(p)) begin
         w.ecc[k] = cw[p-1];
         k++;
      end else begin
         w.data[d] = cw[p-1];
         d++;
      end
   end
   w.ecc[`CCM_ECC_W-1] = cw[`CCM_CW_W-1];
   return w;
endfunction

// xor of the positions of all set bits, zero for a good codeword
function automatic int syndrome(logic [`CCM_CW_W-1:0] cw);
   int s;
   s = 0;
   for (int p = 1; p < `CCM_CW_W; p++) begin
      if (cw[p-1]) s ^= p;
   end
   return s;
endfunction

function automatic logic [`CCM_ECC_W-1:0] model_encode(logic [`CCM_DATA_W-1:0] data);
   logic [5:0] ham;
   ham = 6'(syndrome(to_codeword('{data: data, ecc: '0})));   // data bits only
   return {(^data) ^ (^ham), ham};
endfunction

function automatic ecc_result_t model_decode(ecc_word_t w);
   ecc_result_t          res;
   logic [`CCM_CW_W-1:0] cw;
   int                   s;
   logic                 odd;
   cw  = to_codeword(w);
   s   = syndrome(cw);
   odd = ^cw;
   res.single_err = odd;
   res.double_err = (s != 0) && !odd;
   if (odd && s == 0) cw[`CCM_CW_W-1] = ~cw[`CCM_CW_W-1];   // overall bit itself
   else if (odd && s < `CCM_CW_W) cw[s-1] = ~cw[s-1];
   res.word = from_codeword(cw);
   return res;
endfunction

function automatic range_result_t model_range(logic [`CCM_ADDR_W-1:0] addr);
   range_result_t res;
   res.in_range  = (addr >> `CCM_MASK_BITS) == (`CCM_SADR >> `CCM_MASK_BITS);
   res.in_region = (addr >> (`CCM_ADDR_W - `CCM_REGION_BITS)) ==
                   (`CCM_SADR >> (`CCM_ADDR_W - `CCM_REGION_BITS));
   return res;
endfunction

`endif

/* test/tb_ccm_port.sv */
// ==========================================================================
// CCM port checker testbench
// ==========================================================================
`timescale 1ns/1ps
`include "ccm_params.svh"

module tb_ccm_port;
   import ccm_pkg::*;

   `include "tb_ccm_model.svh"

   localparam int max_wait = 20;   // cycles allowed for outstanding responses

   logic        clk;
   logic        rst_l;
   logic        req_valid;
   ccm_req_t    req;
   logic        resp_valid;
   ccm_resp_t   resp;

   ccm_resp_t   exp_resp;          // expectation for the request on the port
   int          n_req;
   int          n_resp;
   int          n_err;
   int          n_tests;
   int          req_at_start;
   int          err_at_start;
   bit          timed_out;
   int unsigned seed_val;

   ccm_port_top i_dut (
      .clk        (clk),
      .rst_l      (rst_l),
      .req_valid  (req_valid),
      .req        (req),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      if (resp_valid) n_resp++;   // value from before this edge
   end

   // a word counts as clean when the model decoder flags nothing
   function automatic bit decodes_clean(ecc_word_t w);
      ecc_result_t d;
      d = model_decode(w);
      return !d.single_err && !d.double_err;
   endfunction

   a_resp: assert property (@(posedge clk) disable iff (!rst_l)
                            rst_l && req_valid |=> resp_valid && resp == $past(exp_resp))
      else begin
         n_err++;
         $display("Error: %0t ns: response %h does not match the request", $time, resp);
      end

   a_idle: assert property (@(posedge clk) disable iff (!rst_l) !req_valid |=> !resp_valid)
      else begin
         n_err++;
         $display("Error: %0t ns: resp_valid high without a request", $time);
      end

   // the word returned for a write has to pass the model decoder
   a_wr_clean: assert property (@(posedge clk) disable iff (!rst_l)
                                rst_l && req_valid && req.write |=> decodes_clean(resp.word))
      else begin
         n_err++;
         $display("Error: %0t ns: encoded word %h does not decode cleanly", $time, resp.word);
      end

   // held at zero through reset and on the first edge after it
   a_reset: assert property (@(posedge clk) !rst_l || $rose(rst_l) |-> !resp_valid && resp == '0)
      else begin
         n_err++;
         $display("Error: %0t ns: response not cleared around reset", $time);
      end

   function automatic ecc_word_t clean_word(logic [`CCM_DATA_W-1:0] data);
      return '{data: data, ecc: model_encode(data)};
   endfunction

   function automatic logic [`CCM_ADDR_W-1:0] window_addr();
      return `CCM_SADR | ($urandom & ((32'h1 << `CCM_MASK_BITS) - 1));
   endfunction

   function automatic ccm_resp_t expect_resp(ccm_req_t r);
      ecc_result_t   d;
      range_result_t g;
      ccm_resp_t     e;
      d = model_decode(r.rword);
      g = model_range(r.addr);
      e.write      = r.write;
      e.word       = r.write ? clean_word(r.wdata) : d.word;
      e.single_err = !r.write && g.in_range && d.single_err;
      e.double_err = !r.write && g.in_range && d.double_err;
      e.fault      = !g.in_range;
      e.in_region  = g.in_region;
      return e;
   endfunction

   task automatic drive(input ccm_req_t r, input ccm_resp_t e);
      @(negedge clk);
      req_valid = 1'b1;
      req       = r;
      exp_resp  = e;
      n_req++;
   endtask

   task automatic wait_responses();
      int n;
      n = 0;
      while (n_resp < n_req && n < max_wait) begin
         @(negedge clk);
         n++;
      end
      if (n_resp < n_req) timed_out = 1'b1;
   endtask

   task automatic end_test(input string name);
      @(negedge clk);
      req_valid = 1'b0;
      wait_responses();
      n_tests++;
      $display("test %s %0d requests, %0d errors", name, n_req - req_at_start,
               n_err - err_at_start);
      req_at_start = n_req;
      err_at_start = n_err;
   endtask

   task automatic reset_with_traffic();
      for (int i = 0; i < 9; i++) begin
         @(negedge clk);
         req_valid   = 1'b1;   // traffic in reset must not show up
         req.write   = 1'($urandom);
         req.addr    = window_addr();
         req.wdata   = $urandom;
         req.rword   = {$urandom, 7'($urandom)};
      end
      @(negedge clk);
      rst_l     = 1'b1;
      req_valid = 1'b0;
      repeat (3) @(negedge clk);
      end_test("reset");
   endtask

   task automatic clean_reads();
      ccm_req_t  r;
      ccm_resp_t e;
      if (timed_out) return;
      for (int i = 0; i < 30; i++) begin
         r         = '0;
         r.addr    = window_addr();
         r.rword   = clean_word($urandom);
         e         = '0;
         e.word    = r.rword;
         e.in_region = 1'b1;
         drive(r, e);   // back to back
      end
      end_test("clean");
   endtask

   task automatic single_flips();
      ccm_req_t  r;
      ccm_resp_t e;
      ecc_word_t w;
      if (timed_out) return;
      for (int b = 0; b < `CCM_CW_W; b++) begin
         w       = clean_word($urandom);
         r       = '0;
         r.addr  = window_addr();
         r.rword = w ^ (39'h1 << b);
         e       = '0;
         e.word  = w;              // original data and check bits
         e.single_err = 1'b1;
         e.in_region  = 1'b1;
         drive(r, e);
      end
      end_test("single");
   endtask

   task automatic double_flips();
      ccm_req_t r;
      int       b0;
      int       b1;
      if (timed_out) return;
      for (int i = 0; i < 30; i++) begin
         b0      = $urandom % `CCM_CW_W;
         b1      = (b0 + 1 + $urandom % (`CCM_CW_W - 1)) % `CCM_CW_W;
         r       = '0;
         r.addr  = window_addr();
         r.rword = clean_word($urandom) ^ (39'h1 << b0) ^ (39'h1 << b1);
         drive(r, expect_resp(r));
      end
      end_test("double");
   endtask

   task automatic encoded_writes();
      ccm_req_t  r;
      if (timed_out) return;
      for (int i = 0; i < 30; i++) begin
         r.write = 1'b1;
         r.addr  = window_addr();
         r.wdata = $urandom;
         r.rword = {$urandom, 7'($urandom)};   // ignored on writes
         drive(r, expect_resp(r));
      end
      end_test("write");
   endtask

   task automatic outside_window();
      ccm_req_t r;
      if (timed_out) return;
      for (int i = 0; i < 40; i++) begin
         r.write = (i % 4 == 0);
         if (i % 2 == 0) begin
            // outside the window but in the same region
            r.addr = `CCM_SADR ^ (32'h1 << (`CCM_MASK_BITS + $urandom % 11));
         end else begin
            r.addr = $urandom;
            if (model_range(r.addr).in_range) r.addr ^= 32'h0010_0000;
         end
         r.wdata = $urandom;
         r.rword = clean_word($urandom) ^ (39'h1 << ($urandom % `CCM_CW_W));
         drive(r, expect_resp(r));
      end
      end_test("range");
   endtask

   initial begin
      seed_val     = $urandom(32'h86f6ba66);
      rst_l        = 1'b0;
      req_valid    = 1'b0;
      req          = '0;
      exp_resp     = '0;
      n_req        = 0;
      n_resp       = 0;
      n_err        = 0;
      n_tests      = 0;
      req_at_start = 0;
      err_at_start = 0;
      timed_out    = 1'b0;
      reset_with_traffic();
      clean_reads();
      single_flips();
      double_flips();
      encoded_writes();
      outside_window();
      $display("%0d tests, %0d requests, %0d responses, %0d errors",
               n_tests, n_req, n_resp, n_err);
      if (n_err == 0 && !timed_out) begin
         $display("TEST PASS");
      end else begin
         if (timed_out) $display("responses stopped arriving before all requests were answered");
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* verilog/ccm_port_top.sv */
// ==========================================================================
// CCM port checker top
// ==========================================================================
`timescale 1ns/1ps
`include "ccm_params.svh"

module ccm_port_top (
   input  logic                clk,
   input  logic                rst_l,
   input  logic                req_valid,
   input  ccm_pkg::ccm_req_t   req,
   output logic                resp_valid,
   output ccm_pkg::ccm_resp_t  resp
);
   import ccm_pkg::*;

   logic [`CCM_ECC_W-1:0] wr_ecc;
   ecc_result_t           ecc_res;
   range_result_t         range_res;

   // write path
   ecc_encode i_enc (
      .data (req.wdata),
      .ecc  (wr_ecc)
   );

   // read path, check and correct the word from memory
   ecc_decode i_dec (
      .word   (req.rword),
      .result (ecc_res)
   );

   ccm_range_check i_range (
      .addr   (req.addr),
      .result (range_res)
   );

   ccm_resp_stage i_resp (
      .clk        (clk),
      .rst_l      (rst_l),
      .req_valid  (req_valid),
      .write      (req.write),
      .wdata      (req.wdata),
      .wr_ecc     (wr_ecc),
      .ecc_res    (ecc_res),
      .range_res  (range_res),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

endmodule

/* verilog/ccm_resp_stage.sv */
// ==========================================================================
// CCM port response register
// ==========================================================================
`timescale 1ns/1ps
`include "ccm_params.svh"

module ccm_resp_stage (
   input  logic                    clk,
   input  logic                    rst_l,
   input  logic                    req_valid,
   input  logic                    write,
   input  logic [`CCM_DATA_W-1:0]  wdata,
   input  logic [`CCM_ECC_W-1:0]   wr_ecc,      // check bits for wdata
   input  ccm_pkg::ecc_result_t    ecc_res,     // decode of the read word
   input  ccm_pkg::range_result_t  range_res,
   output logic                    resp_valid,
   output ccm_pkg::ccm_resp_t      resp
);
   import ccm_pkg::*;

   ecc_word_t wr_word;
   logic      rd_chk;     // in-range read, ecc flags count
   ccm_resp_t resp_d;

   assign wr_word = '{data: wdata, ecc: wr_ecc};

   // error flags only mean something for a read that hits the CCM
   assign rd_chk = ~write & range_res.in_range;

   always_comb begin
      resp_d.write      = write;
      resp_d.word       = write ? wr_word : ecc_res.word;   // word reported on faults too
      resp_d.single_err = rd_chk & ecc_res.single_err;
      resp_d.double_err = rd_chk & ecc_res.double_err;
      resp_d.fault      = ~range_res.in_range;
      resp_d.in_region  = range_res.in_region;
   end

   // response holds its last value between requests
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         resp <= '0;
      end else if (req_valid) begin
         resp <= resp_d;
      end
   end

   // one response per request, high for a single cycle
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= req_valid;
      end
   end

endmodule

/* verilog/ccm_range_check.sv */
// ==========================================================================
// CCM address window check
// ==========================================================================
`timescale 1ns/1ps
`include "ccm_params.svh"

module ccm_range_check (
   input  logic [`CCM_ADDR_W-1:0] addr,
   output ccm_pkg::range_result_t result
);

   localparam int                     addr_msb   = `CCM_ADDR_W - 1;
   localparam int                     mask_bits  = `CCM_MASK_BITS;
   localparam int                     region_lsb = `CCM_ADDR_W - `CCM_REGION_BITS;
   localparam logic [`CCM_ADDR_W-1:0] start_addr = `CCM_SADR;

   logic range_hit;
   logic region_hit;

   // window is a power of two in size and aligned, so everything above
   // the size bits has to equal the start address
   assign range_hit = (addr[addr_msb:mask_bits] == start_addr[addr_msb:mask_bits]);

   // region is named by the top address bits only
   assign region_hit = (addr[addr_msb:region_lsb] == start_addr[addr_msb:region_lsb]);

   assign result = '{
      in_range:  range_hit,
      in_region: region_hit
   };

endmodule

/* ecc/ecc_decode.sv */
// ==========================================================================
// SECDED decoder with single-bit correction
// ==========================================================================
`timescale 1ns/1ps
`include "ccm_params.svh"

module ecc_decode (
   input  ccm_pkg::ecc_word_t   word,
   output ccm_pkg::ecc_result_t result
);
   import ccm_pkg::*;

   logic [`CCM_ECC_W-1:0] ecc_gen;      // check bits recomputed from data
   logic [`CCM_ECC_W-1:0] syn_raw;
   logic                  par_err;      // overall parity of received word
   logic [`CCM_ECC_W-1:0] chk;          // {parity, hamming syndrome}
   logic                  single_err;
   logic                  double_err;
   logic [`CCM_CW_W-1:0]  cw_in;
   logic [`CCM_CW_W-1:0]  err_mask;
   logic [`CCM_CW_W-1:0]  cw_fix;
   ecc_word_t             fixed_word;

   ecc_encode i_enc (
      .data (word.data),
      .ecc  (ecc_gen)
   );

   assign syn_raw = ecc_gen ^ word.ecc;

   // xor of the full 7-bit difference equals the parity of data and
   // all received check bits
   assign par_err = ^syn_raw;
   assign chk     = {par_err, syn_raw[5:0]};

   // odd parity means one flipped bit, even parity with a nonzero
   // syndrome means two
   assign single_err = (chk != '0) &  par_err;
   assign double_err = (chk != '0) & ~par_err;

   // interleaved codeword, check bits at the power-of-two positions
   assign cw_in = {word.ecc[6], word.data[31:26],
                   word.ecc[5], word.data[25:11],
                   word.ecc[4], word.data[10:4],
                   word.ecc[3], word.data[3:1],
                   word.ecc[2], word.data[0],
                   word.ecc[1:0]};

   always_comb begin
      err_mask = '0;
      for (int i = 0; i < `CCM_CW_W - 1; i++) begin
         err_mask[i] = (chk[5:0] == 6'(i + 1));   // syndrome is position + 1
      end
      // only the overall parity bit is off
      err_mask[`CCM_CW_W-1] = (chk == 7'b100_0000);
   end

   assign cw_fix = single_err ? (cw_in ^ err_mask) : cw_in;

   // pull data and check bits back out of the corrected codeword
   assign fixed_word = '{
      data: {cw_fix[37:32], cw_fix[30:16], cw_fix[14:8], cw_fix[6:4], cw_fix[2]},
      ecc:  {cw_fix[38], cw_fix[31], cw_fix[15], cw_fix[7], cw_fix[3], cw_fix[1:0]}
   };

   assign result = '{
      word:       fixed_word,
      single_err: single_err,
      double_err: double_err
   };

endmodule

/* ecc/ecc_encode.sv */
// ==========================================================================
// SECDED check-bit encoder
// ==========================================================================
`timescale 1ns/1ps
`include "ccm_params.svh"

module ecc_encode (
   input  logic [`CCM_DATA_W-1:0] data,
   output logic [`CCM_ECC_W-1:0]  ecc
);

   // data bits covered by each hamming check bit
   // check bit k covers the codeword positions whose index has bit k set,
   // with data placed around check bits at positions 1, 2, 4, 8, 16 and 32
   localparam logic [5:0][`CCM_DATA_W-1:0] grp_mask = {
      32'hfc00_0000,   // ecc[5], data 31..26
      32'h03ff_f800,   // ecc[4], data 25..11
      32'h03fc_07f0,   // ecc[3]
      32'he3c3_c78e,   // ecc[2]
      32'h9b33_366d,   // ecc[1]
      32'h56aa_ad5b    // ecc[0]
   };

   logic [5:0] ham;   // hamming check bits
   logic       ovr;   // overall parity

   for (genvar i = 0; i < 6; i++) begin : g_ham
      assign ham[i] = ^(data & grp_mask[i]);
   end

   // overall parity over data and the six hamming bits, makes the
   // whole codeword even
   assign ovr = (^data) ^ (^ham);

   assign ecc = {ovr, ham};

endmodule

/* common/ccm_pkg.sv */
// ==========================================================================
// CCM port shared types
// ==========================================================================
`include "ccm_params.svh"

package ccm_pkg;

   // protected word as it sits in the CCM
   typedef struct packed {
      logic [`CCM_DATA_W-1:0] data;
      logic [`CCM_ECC_W-1:0]  ecc;
   } ecc_word_t;

   // one access on the port
   typedef struct packed {
      logic                   write;
      logic [`CCM_ADDR_W-1:0] addr;
      logic [`CCM_DATA_W-1:0] wdata;
      ecc_word_t              rword;   // word read back from memory
   } ccm_req_t;

   // decoder output
   typedef struct packed {
      ecc_word_t word;        // corrected data and check bits
      logic      single_err;  // corrected
      logic      double_err;  // detected only
   } ecc_result_t;

   // address window check
   typedef struct packed {
      logic in_range;
      logic in_region;
   } range_result_t;

   // registered response
   typedef struct packed {
      logic      write;
      ecc_word_t word;        // encoded word on writes, corrected word on reads
      logic      single_err;
      logic      double_err;
      logic      fault;       // address outside the CCM window
      logic      in_region;
   } ccm_resp_t;

endpackage

/* common/ccm_params.svh */
// ==========================================================================
// CCM port widths and window
// ==========================================================================
`ifndef CCM_PARAMS_SVH
`define CCM_PARAMS_SVH

// data and protected word widths
`define CCM_DATA_W        32
`define CCM_ECC_W         7
`define CCM_CW_W          39    // data plus check bits, interleaved

// address
`define CCM_ADDR_W        32

// CCM window
`define CCM_SADR          32'hf004_0000
`define CCM_SIZE_KB       128   // power of two only

// top address bits that name a region
`define CCM_REGION_BITS   4

// lowest address bit that has to match the start address
`define CCM_MASK_BITS     (10 + $clog2(`CCM_SIZE_KB))

`endif
